/* sources.f */
hw/enet_feed_pkg.sv
hw/power_on_reset.sv
hw/dm9000a_bus.sv
hw/rt_data_feed.sv
hw/word_fifo.sv
hw/hex_display.sv
hw/enet_feed_top.sv
tb/dm9000a_model.sv
tb/enet_feed_assert.sv
tb/tb_enet_feed.sv

/* Makefile */
# Verilator build and run for the Ethernet receive feed

VERILATOR ?= verilator
TOP       ?= tb_enet_feed
RTL_TOP   ?= enet_feed_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

RTL_FILES := $(shell grep '^hw/' $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Exit status of the simulation is the test result
run: build
	$(SIM_BIN)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_FILES)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* tb/tb_enet_feed.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_enet_feed;
   import enet_feed_pkg::*;

   localparam int CLK_PERIOD     = 40;
   localparam int TIMEOUT_CYCLES = 20000;  // 200 words at about 9 clocks each plus margin
   localparam bit MODEL_LINK     = 1'b1;
   // Active low digit patterns with bit 6 as segment g
   localparam seg_t SEG_TABLE [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                                       7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};

   logic        clk;
   logic        rst;
   logic        read_one;
   logic        show_rx_lo;
   logic        show_data;
   logic        new_pkt;
   logic        enet_int;
   enet_word_t  enet_data_in;
   enet_word_t  enet_data_out;
   logic        enet_data_oe;
   logic        enet_cmd;
   logic        enet_cs_n;
   logic        enet_wr_n;
   logic        enet_rd_n;
   logic        enet_rst_n;
   logic        have_data;
   logic        link_status;
   hex_digits_t digits;
   int          seed;
   int          failures       = 0;
   int          cycles         = 0;
   int          rst_low_pulses = 0;  // Falling edges of enet_rst_n
   logic        rst_n_q        = 1'b1;
   logic        count_pulses   = 1'b0;
   string       test_name      = "none";
   enet_word_t  expected_words [$];   // Words still to pop in order

   enet_feed_top dut_i (
      .clk           (clk),
      .rst           (rst),
      .enet_int      (enet_int),
      .enet_data_in  (enet_data_in),
      .enet_data_out (enet_data_out),
      .enet_data_oe  (enet_data_oe),
      .enet_cmd      (enet_cmd),
      .enet_cs_n     (enet_cs_n),
      .enet_wr_n     (enet_wr_n),
      .enet_rd_n     (enet_rd_n),
      .enet_rst_n    (enet_rst_n),
      .read_one      (read_one),
      .show_rx_lo    (show_rx_lo),
      .show_data     (show_data),
      .have_data     (have_data),
      .link_status   (link_status),
      .digits        (digits)
   );

   dm9000a_model #(.LINK_UP(MODEL_LINK)) model_i (
      .clk        (clk),
      .enet_rst_n (enet_rst_n),
      .new_pkt    (new_pkt),
      .cmd        (enet_cmd),
      .cs_n       (enet_cs_n),
      .wr_n       (enet_wr_n),
      .rd_n       (enet_rd_n),
      .bus_wdata  (enet_data_out),
      .bus_rdata  (enet_data_in),
      .enet_int   (enet_int)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic stop_with_failure();
      $display("TEST RESULT: FAIL");
      $fatal(1, "Simulation stopped after a failure");
   endtask

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         failures++;
         $display("CHECK FAILED %s: %s expected 0x%0h actual 0x%0h",
                  test_name, what, expected, actual);
         stop_with_failure();
      end
   endtask

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles in test %s", cycles, test_name);
         stop_with_failure();
      end
   end

   always @(posedge clk) begin
      rst_n_q <= enet_rst_n;
      if (count_pulses && rst_n_q && !enet_rst_n) begin
         rst_low_pulses <= rst_low_pulses + 1;
      end
   end

   // Inverse of the segment table or -1 for no hex digit
   function automatic int seg_value(input seg_t seg);
      int val;
      val = -1;
      for (int i = 0; i < 16; i++) begin
         if (SEG_TABLE[i] == seg) begin
            val = i;
         end
      end
      return val;
   endfunction

   function automatic int word_on_digits(input seg_t d3, input seg_t d2, input seg_t d1,
                                         input seg_t d0);
      seg_t segs [4];
      int   val;
      int   word;
      segs = '{d3, d2, d1, d0};
      word = 0;
      for (int i = 0; i < 4; i++) begin
         val = seg_value(segs[i]);
         if (val < 0) begin
            return -1;
         end
         word = word * 16 + val;
      end
      return word;
   endfunction

   function automatic int count_on_display();
      int hi;
      int lo;
      hi = seg_value(digits.digit1);
      lo = seg_value(digits.digit0);
      if (hi < 0 || lo < 0) begin
         return -1;
      end
      return hi * 16 + lo;
   endfunction

   function automatic int header_on_display();
      return word_on_digits(digits.digit7, digits.digit6, digits.digit5, digits.digit4);
   endfunction

   // Fills the model buffer and raises its interrupt
   task automatic load_packet(input enet_word_t status, input enet_word_t len_bytes,
                              input int words);
      enet_word_t w;
      model_i.rx_mem[0] = status;
      model_i.rx_mem[1] = len_bytes;
      for (int i = 0; i < words; i++) begin
         w = enet_word_t'($random(seed));
         model_i.rx_mem[2 + i] = w;
         if (status[7:0] == 8'h01) begin
            expected_words.push_back(w);  // Only a ready packet reaches the FIFO
         end
      end
      new_pkt = 1'b1;
      @(negedge clk);
      new_pkt = 1'b0;
   endtask

   task automatic wait_for_clear(input int clears_before);
      while (model_i.isr_clears == clears_before) begin
         @(negedge clk);
      end
      repeat (2) @(negedge clk);  // Sequencer back in idle
   endtask

   task automatic pop_and_check();
      enet_word_t exp;
      exp = expected_words.pop_front();
      while (!have_data) begin
         @(negedge clk);
      end
      check_value("FIFO head word",
                  exp, word_on_digits(digits.digit3, digits.digit2, digits.digit1, digits.digit0));
      read_one = 1'b1;
      @(negedge clk);
      read_one = 1'b0;
   endtask

   task automatic init_test();
      test_name = "init";
      while (enet_rst_n) begin
         @(negedge clk);
      end
      while (!enet_rst_n) begin
         @(negedge clk);
      end
      while (model_i.nsr_reads == 0) begin
         @(negedge clk);
      end
      @(negedge clk);
      check_value("chip reset pulses", 1, rst_low_pulses);
      check_value("link status", MODEL_LINK, link_status);
      check_value("have_data", 0, have_data);
      check_value("header digits", 0, header_on_display());
      check_value("count digits", 0, count_on_display());
      check_value("digit 3", SEG_BLANK, digits.digit3);
      check_value("digit 2", SEG_BLANK, digits.digit2);
   endtask

   task automatic single_packet_test();
      enet_word_t status;
      int         clears;
      test_name = "single_packet";
      status    = {8'($random(seed)), 8'h01};
      clears    = model_i.isr_clears;
      load_packet(status, 16'd19, 10);  // Odd length rounds up to 10 words
      while (!have_data) begin
         @(negedge clk);
      end
      wait_for_clear(clears);
      check_value("count digits", 'h0A, count_on_display());
      check_value("ISR clears", clears + 1, model_i.isr_clears);
      check_value("enet_int after clear", 0, enet_int);
      check_value("header status digits", status, header_on_display());
      show_rx_lo = 1'b1;
      @(negedge clk);
      check_value("header length digits", 19, header_on_display());
      show_rx_lo = 1'b0;
   endtask

   task automatic readout_test();
      test_name = "readout_order";
      show_data = 1'b1;
      @(negedge clk);
      while (expected_words.size() > 0) begin
         pop_and_check();
      end
      check_value("have_data after last pop", 0, have_data);
      show_data = 1'b0;
      @(negedge clk);
   endtask

   task automatic backpressure_test();
      int clears;
      int reads_before;
      test_name    = "back_pressure";
      clears       = model_i.isr_clears;
      reads_before = model_i.mrcmd_reads;
      load_packet({8'($random(seed)), 8'h01}, 16'd400, 200);
      while (count_on_display() != 'h80) begin
         @(negedge clk);
      end
      repeat (30) @(negedge clk);  // Several access times with the FIFO full
      check_value("reads while full", 2 + 128, model_i.mrcmd_reads - reads_before);
      show_data = 1'b1;
      @(negedge clk);
      while (expected_words.size() > 0) begin
         pop_and_check();
      end
      wait_for_clear(clears);
      check_value("total reads", 2 + 200, model_i.mrcmd_reads - reads_before);
      check_value("have_data after last pop", 0, have_data);
      show_data = 1'b0;
      @(negedge clk);
   endtask

   task automatic non_ready_test();
      int clears;
      int reads_before;
      test_name    = "non_ready_header";
      clears       = model_i.isr_clears;
      reads_before = model_i.mrcmd_reads;
      load_packet({8'($random(seed)), 8'h00}, 16'd8, 4);
      wait_for_clear(clears);
      repeat (4) @(negedge clk);
      check_value("memory reads", 1, model_i.mrcmd_reads - reads_before);
      check_value("have_data", 0, have_data);
      check_value("count digits", 0, count_on_display());
      check_value("enet_int after clear", 0, enet_int);
   endtask

   initial begin
      seed       = 43;
      rst        = 1'b1;
      read_one   = 1'b0;
      show_rx_lo = 1'b0;
      show_data  = 1'b0;
      new_pkt    = 1'b0;
      repeat (3) @(negedge clk);
      rst          = 1'b0;
      count_pulses = 1'b1;
      init_test();
      single_packet_test();
      readout_test();
      backpressure_test();
      non_ready_test();
      if (failures == 0) begin
         $display("TEST RESULT: PASS");
         $finish;
      end else begin
         stop_with_failure();
      end
   end

endmodule

`default_nettype wire

/* tb/enet_feed_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module enet_feed_assert (
   input wire clk,
   input wire rst,
   input wire enet_cs_n,
   input wire enet_wr_n,
   input wire enet_rd_n,
   input wire enet_data_oe
);
   logic [3:0] cs_low_cycles;  // Clocks since cs_n fell

   always_ff @(posedge clk) begin
      if (rst || enet_cs_n) begin
         cs_low_cycles <= '0;
      end else begin
         cs_low_cycles <= cs_low_cycles + 1'b1;
      end
   end

   strobes_exclusive: assert property (@(posedge clk) disable iff (rst)
      !(!enet_rd_n && !enet_wr_n))
      else $error("rd_n and wr_n low in the same cycle");

   strobe_needs_cs: assert property (@(posedge clk) disable iff (rst)
      (!enet_rd_n || !enet_wr_n) |-> !enet_cs_n)
      else $error("Strobe low while cs_n is high");

   oe_only_when_writing: assert property (@(posedge clk) disable iff (rst)
      enet_data_oe |-> (!enet_cs_n && enet_rd_n))
      else $error("data_oe high outside an index or write phase");

   access_length: assert property (@(posedge clk) disable iff (rst)
      !enet_cs_n |-> (cs_low_cycles < 4'd8))
      else $error("cs_n held low longer than 8 cycles");

endmodule

bind dm9000a_bus enet_feed_assert bus_assert_i (
   .clk          (clk),
   .rst          (rst),
   .enet_cs_n    (enet_cs_n),
   .enet_wr_n    (enet_wr_n),
   .enet_rd_n    (enet_rd_n),
   .enet_data_oe (enet_data_oe)
);

`default_nettype wire

/* tb/dm9000a_model.sv */
`timescale 1ns/1ps
`default_nettype none

module dm9000a_model #(
   parameter bit LINK_UP = 1'b1  // Link bit reported in NSR
) (
   input  wire         clk,
   input  wire         enet_rst_n,
   input  wire         new_pkt,     // Packet placed in rx_mem, raise interrupt
   input  wire         cmd,         // Low selects the index port
   input  wire         cs_n,
   input  wire         wr_n,
   input  wire         rd_n,
   input  wire  [15:0] bus_wdata,
   output logic [15:0] bus_rdata,
   output logic        enet_int
);
   import enet_feed_pkg::*;

   logic [15:0] rx_mem [512];          // Header then data, loaded by the testbench
   logic [7:0]  index       = 8'h00;   // Last register index written
   logic [15:0] isr         = '0;
   logic [8:0]  rd_ptr      = '0;      // MRCMD read pointer
   logic        wr_n_q      = 1'b1;
   logic        rd_n_q      = 1'b1;
   int          mrcmd_reads = 0;       // Completed memory reads
   int          nsr_reads   = 0;
   int          isr_clears  = 0;       // ISR data writes seen

   assign enet_int = isr[ISR_PR_BIT];

   // Read data follows the index, stable through the strobe
   always_comb begin
      case (index)
         REG_NSR:   bus_rdata = 16'(LINK_UP) << NSR_LINK_BIT;
         REG_ISR:   bus_rdata = isr;
         REG_MRCMD: bus_rdata = rx_mem[rd_ptr];
         default:   bus_rdata = 16'h0000;
      endcase
   end

   always @(posedge clk) begin
      wr_n_q <= wr_n;
      rd_n_q <= rd_n;
      if (!enet_rst_n) begin
         index  <= 8'h00;  // Chip reset pin
         isr    <= '0;
         rd_ptr <= '0;
      end else begin
         if (new_pkt) begin
            rd_ptr          <= '0;
            isr[ISR_PR_BIT] <= 1'b1;
         end
         if (!cs_n && !wr_n && !cmd) begin
            index <= bus_wdata[7:0];  // Index phase
         end
         if (!cs_n && !wr_n && cmd && index == REG_ISR) begin
            isr <= isr & ~bus_wdata;  // Write 1 clears
         end
         if (!wr_n_q && wr_n && cmd && index == REG_ISR) begin
            isr_clears <= isr_clears + 1;
         end
         // Read ends on the rising rd_n
         if (!rd_n_q && rd_n && index == REG_MRCMD) begin
            rd_ptr      <= rd_ptr + 1'b1;  // Auto increment
            mrcmd_reads <= mrcmd_reads + 1;
         end
         if (!rd_n_q && rd_n && index == REG_NSR) begin
            nsr_reads <= nsr_reads + 1;
         end
      end
   end

endmodule

`default_nettype wire

/* hw/enet_feed_top.sv */
`timescale 1ns/1ps
`default_nettype none

module enet_feed_top (
   input  wire                          clk,
   input  wire                          rst,
   input  wire                          enet_int,
   input  wire enet_feed_pkg::enet_word_t enet_data_in,
   output enet_feed_pkg::enet_word_t    enet_data_out,
   output logic                         enet_data_oe,
   output logic                         enet_cmd,
   output logic                         enet_cs_n,
   output logic                         enet_wr_n,
   output logic                         enet_rd_n,
   output logic                         enet_rst_n,
   input  wire                          read_one,
   input  wire                          show_rx_lo,
   input  wire                          show_data,
   output logic                         have_data,
   output logic                         link_status,
   output enet_feed_pkg::hex_digits_t   digits
);
   import enet_feed_pkg::*;

   logic        po_reset;
   logic        global_reset;
   logic        bus_start;
   logic        bus_done;
   bus_req_t    bus_req;
   enet_word_t  bus_rdata;
   logic        push;
   enet_word_t  push_data;
   logic        fifo_full;
   logic        fifo_empty;
   enet_word_t  fifo_head;
   fifo_count_t fifo_count;
   rx_header_t  rx_header;

   assign global_reset = po_reset | rst;  // Startup or external
   assign have_data    = ~fifo_empty;

   power_on_reset por_i (
      .clk   (clk),
      .reset (po_reset)
   );

   rt_data_feed feed_i (
      .clk         (clk),
      .rst         (global_reset),
      .enet_int    (enet_int),
      .enet_rst_n  (enet_rst_n),
      .bus_start   (bus_start),
      .req         (bus_req),
      .bus_done    (bus_done),
      .rdata       (bus_rdata),
      .push        (push),
      .push_data   (push_data),
      .fifo_full   (fifo_full),
      .link_status (link_status),
      .rx_header   (rx_header)
   );

   dm9000a_bus bus_i (
      .clk           (clk),
      .rst           (global_reset),
      .bus_start     (bus_start),
      .req           (bus_req),
      .bus_done      (bus_done),
      .rdata         (bus_rdata),
      .enet_cmd      (enet_cmd),
      .enet_cs_n     (enet_cs_n),
      .enet_wr_n     (enet_wr_n),
      .enet_rd_n     (enet_rd_n),
      .enet_data_out (enet_data_out),
      .enet_data_oe  (enet_data_oe),
      .enet_data_in  (enet_data_in)
   );

   word_fifo fifo_i (
      .clk       (clk),
      .rst       (global_reset),
      .push      (push),
      .push_data (push_data),
      .pop       (read_one),  // Gated by empty inside
      .head      (fifo_head),
      .count     (fifo_count),
      .full      (fifo_full),
      .empty     (fifo_empty)
   );

   hex_display hex_i (
      .rx_header  (rx_header),
      .head       (fifo_head),
      .count      (fifo_count),
      .show_rx_lo (show_rx_lo),
      .show_data  (show_data),
      .digits     (digits)
   );

endmodule

`default_nettype wire

/* hw/hex_display.sv */
`timescale 1ns/1ps
`default_nettype none

module hex_display (
   input  wire enet_feed_pkg::rx_header_t  rx_header,
   input  wire enet_feed_pkg::enet_word_t  head,
   input  wire enet_feed_pkg::fifo_count_t count,
   input  wire                             show_rx_lo,
   input  wire                             show_data,
   output enet_feed_pkg::hex_digits_t      digits
);
   import enet_feed_pkg::*;

   enet_word_t upper_val;  // Header word on digits 7..4
   enet_word_t lower_val;  // FIFO head or count on digits 3..0

   // Active low, bit 6 is segment g
   function automatic seg_t hex_to_seg(input hex_nibble_t val);
      case (val)
         4'h0:    hex_to_seg = 7'h40;
         4'h1:    hex_to_seg = 7'h79;
         4'h2:    hex_to_seg = 7'h24;
         4'h3:    hex_to_seg = 7'h30;
         4'h4:    hex_to_seg = 7'h19;
         4'h5:    hex_to_seg = 7'h12;
         4'h6:    hex_to_seg = 7'h02;
         4'h7:    hex_to_seg = 7'h78;
         4'h8:    hex_to_seg = 7'h00;
         4'h9:    hex_to_seg = 7'h10;
         4'hA:    hex_to_seg = 7'h08;
         4'hB:    hex_to_seg = 7'h03;
         4'hC:    hex_to_seg = 7'h46;
         4'hD:    hex_to_seg = 7'h21;
         4'hE:    hex_to_seg = 7'h06;
         default: hex_to_seg = 7'h0E;  // F
      endcase
   endfunction

   always_comb begin
      upper_val     = show_rx_lo ? rx_header.lo : rx_header.hi;
      lower_val     = show_data ? head : {8'h00, count};
      digits.digit7 = hex_to_seg(upper_val[15:12]);
      digits.digit6 = hex_to_seg(upper_val[11:8]);
      digits.digit5 = hex_to_seg(upper_val[7:4]);
      digits.digit4 = hex_to_seg(upper_val[3:0]);
      // Upper count digits blanked, count fits in two
      digits.digit3 = show_data ? hex_to_seg(lower_val[15:12]) : SEG_BLANK;
      digits.digit2 = show_data ? hex_to_seg(lower_val[11:8]) : SEG_BLANK;
      digits.digit1 = hex_to_seg(lower_val[7:4]);
      digits.digit0 = hex_to_seg(lower_val[3:0]);
   end

endmodule

`default_nettype wire

/* hw/word_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module word_fifo (
   input  wire                          clk,
   input  wire                          rst,
   input  wire                          push,
   input  wire enet_feed_pkg::enet_word_t push_data,
   input  wire                          pop,
   output enet_feed_pkg::enet_word_t    head,
   output enet_feed_pkg::fifo_count_t   count,
   output logic                         full,
   output logic                         empty
);
   import enet_feed_pkg::*;

   enet_word_t                       mem [FIFO_DEPTH];
   logic [$clog2(FIFO_DEPTH)-1:0]    wr_ptr;   // Wraps naturally, depth is 2^n
   logic [$clog2(FIFO_DEPTH)-1:0]    rd_ptr;
   logic                             do_push;
   logic                             do_pop;

   assign empty   = (count == '0);
   assign full    = (int'(count) == FIFO_DEPTH);
   assign do_push = push && !full;   // Overflow dropped
   assign do_pop  = pop && !empty;   // Pop on empty ignored
   assign head    = mem[rd_ptr];     // Fall through, head visible now

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // Both or neither
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

endmodule

`default_nettype wire

/* hw/rt_data_feed.sv */
`timescale 1ns/1ps
`default_nettype none

module rt_data_feed (
   input  wire                          clk,
   input  wire                          rst,
   input  wire                          enet_int,
   output logic                         enet_rst_n,
   output logic                         bus_start,
   output enet_feed_pkg::bus_req_t      req,
   input  wire                          bus_done,
   input  wire enet_feed_pkg::enet_word_t rdata,
   output logic                         push,
   output enet_feed_pkg::enet_word_t    push_data,
   input  wire                          fifo_full,
   output logic                         link_status,
   output enet_feed_pkg::rx_header_t    rx_header
);
   import enet_feed_pkg::*;

   feed_state_t                            state;
   logic                                   pending;     // Access issued, awaiting done
   logic [$clog2(CHIP_RST_CYCLES+1)-1:0]   rst_cnt;     // Chip reset pulse length
   enet_word_t                             words_left;  // Data words still to read
   enet_word_t                             status_q;    // Header status until length
   logic                                   needs_bus;

   // Every state except reset and idle runs exactly one access
   assign needs_bus = !(state inside {chip_reset, idle});
   assign bus_start = needs_bus && !pending && !(state == read_data && fifo_full);

   always_comb begin
      req.write = 1'b0;
      req.index = REG_MRCMD;  // Header and data reads
      req.wdata = '0;
      case (state)
         read_link: begin
            req.index = REG_NSR;
         end
         read_isr: begin
            req.index = REG_ISR;
         end
         clear_isr: begin
            req.write = 1'b1;
            req.index = REG_ISR;
            req.wdata = enet_word_t'(1) << ISR_PR_BIT;  // Write 1 to clear
         end
         default: begin
            req.index = REG_MRCMD;
         end
      endcase
   end

   assign push      = (state == read_data) && bus_done;  // One word per data read
   assign push_data = rdata;

   always_ff @(posedge clk) begin
      if (rst) begin
         state       <= chip_reset;
         pending     <= 1'b0;
         rst_cnt     <= '0;
         enet_rst_n  <= 1'b1;
         link_status <= 1'b0;
         rx_header   <= '0;
         words_left  <= '0;
      end else begin
         if (bus_start) begin
            pending <= 1'b1;
         end else if (bus_done) begin
            pending <= 1'b0;
         end
         case (state)
            chip_reset: begin
               if (int'(rst_cnt) == CHIP_RST_CYCLES) begin
                  enet_rst_n <= 1'b1;  // Release the chip
                  state      <= read_link;
               end else begin
                  rst_cnt    <= rst_cnt + 1'b1;
                  enet_rst_n <= 1'b0;
               end
            end
            read_link: begin
               if (bus_done) begin
                  link_status <= rdata[NSR_LINK_BIT];
                  state       <= idle;
               end
            end
            idle: begin
               if (enet_int) begin
                  state <= read_isr;
               end
            end
            read_isr: begin
               if (bus_done) begin
                  state <= rdata[ISR_PR_BIT] ? read_header_status : idle;
               end
            end
            read_header_status: begin
               if (bus_done) begin
                  // Not ready, just acknowledge the interrupt
                  state <= (rdata[7:0] == RX_READY) ? read_header_len : clear_isr;
               end
            end
            read_header_len: begin
               if (bus_done) begin
                  rx_header  <= {status_q, rdata};
                  words_left <= enet_word_t'(({1'b0, rdata} + 17'd1) >> 1);  // Bytes to words
                  state      <= (rdata == '0) ? clear_isr : read_data;
               end
            end
            read_data: begin
               if (bus_done) begin
                  words_left <= words_left - 1'b1;
                  if (words_left == enet_word_t'(1)) begin
                     state <= clear_isr;  // Last word pushed
                  end
               end
            end
            clear_isr: begin
               if (bus_done) begin
                  state <= idle;
               end
            end
            default: begin
               state <= idle;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == read_header_status && bus_done) begin
         status_q <= rdata;
      end
   end

endmodule

`default_nettype wire

/* hw/dm9000a_bus.sv */
`timescale 1ns/1ps
`default_nettype none

module dm9000a_bus (
   input  wire                        clk,
   input  wire                        rst,
   input  wire                        bus_start,
   input  wire enet_feed_pkg::bus_req_t req,
   output logic                       bus_done,
   output enet_feed_pkg::enet_word_t  rdata,
   output logic                       enet_cmd,
   output logic                       enet_cs_n,
   output logic                       enet_wr_n,
   output logic                       enet_rd_n,
   output enet_feed_pkg::enet_word_t  enet_data_out,
   output logic                       enet_data_oe,
   input  wire enet_feed_pkg::enet_word_t enet_data_in
);
   import enet_feed_pkg::*;

   logic                                  busy;        // Access in progress
   logic                                  data_phase;  // 0 = index, 1 = data
   logic [$clog2(BUS_PHASE_CYCLES)-1:0]   cyc;         // Clock within phase
   bus_req_t                              req_q;       // Held for the access
   logic                                  nxt_busy;
   logic                                  nxt_phase;
   logic [$clog2(BUS_PHASE_CYCLES)-1:0]   nxt_cyc;
   bus_req_t                              req_sel;
   logic                                  nxt_strobe;

   // Next counter state, outputs are decoded from it and registered
   always_comb begin
      nxt_busy  = busy;
      nxt_phase = data_phase;
      nxt_cyc   = cyc;
      if (!busy) begin
         if (bus_start) begin
            nxt_busy  = 1'b1;
            nxt_phase = 1'b0;  // Index phase first
            nxt_cyc   = '0;
         end
      end else if (int'(cyc) == BUS_PHASE_CYCLES - 1) begin
         nxt_cyc = '0;
         if (data_phase) begin
            nxt_busy = 1'b0;  // Both phases done
         end else begin
            nxt_phase = 1'b1;
         end
      end else begin
         nxt_cyc = cyc + 1'b1;
      end
   end

   assign req_sel = busy ? req_q : req;  // New request used on the start cycle

   // Strobe cycles sit between setup and hold
   assign nxt_strobe = nxt_busy && (int'(nxt_cyc) >= 1)
                       && (int'(nxt_cyc) <= BUS_PHASE_CYCLES - 2);

   always_ff @(posedge clk) begin
      if (rst) begin
         busy         <= 1'b0;
         data_phase   <= 1'b0;
         cyc          <= '0;
         bus_done     <= 1'b0;
         enet_cmd     <= 1'b0;
         enet_cs_n    <= 1'b1;
         enet_wr_n    <= 1'b1;
         enet_rd_n    <= 1'b1;
         enet_data_oe <= 1'b0;
      end else begin
         busy         <= nxt_busy;
         data_phase   <= nxt_phase;
         cyc          <= nxt_cyc;
         bus_done     <= nxt_busy && nxt_phase && (int'(nxt_cyc) == BUS_PHASE_CYCLES - 1);
         enet_cmd     <= nxt_busy && nxt_phase;  // Low selects the index port
         enet_cs_n    <= !nxt_busy;
         enet_wr_n    <= !(nxt_strobe && (!nxt_phase || req_sel.write));
         enet_rd_n    <= !(nxt_strobe && nxt_phase && !req_sel.write);
         enet_data_oe <= nxt_busy && (!nxt_phase || req_sel.write);
      end
   end

   always_ff @(posedge clk) begin
      if (!busy && bus_start) begin
         req_q <= req;
      end
      enet_data_out <= nxt_phase ? req_sel.wdata : {8'h00, req_sel.index};
      // Capture on the last strobe clock of a read data phase
      if (busy && data_phase && !req_q.write && (int'(cyc) == BUS_PHASE_CYCLES - 2)) begin
         rdata <= enet_data_in;
      end
   end

endmodule

`default_nettype wire

/* hw/power_on_reset.sv */
`timescale 1ns/1ps
`default_nettype none

module power_on_reset (
   input  wire  clk,
   output logic reset
);
   import enet_feed_pkg::*;

   // Counts up from zero after configuration
   logic [$clog2(POR_CYCLES+1)-1:0] por_count = '0;

   assign reset = int'(por_count) < POR_CYCLES;  // High until count saturates

   always_ff @(posedge clk) begin
      if (reset) begin
         por_count <= por_count + 1'b1;  // Stops at POR_CYCLES
      end
   end

endmodule

`default_nettype wire

/* hw/enet_feed_pkg.sv */
`default_nettype none

package enet_feed_pkg;

   typedef logic [15:0] enet_word_t;   // Chip host data bus
   typedef logic [7:0]  reg_index_t;   // Chip register address
   typedef logic [7:0]  fifo_count_t;  // Holds 0 to FIFO_DEPTH
   typedef logic [3:0]  hex_nibble_t;  // One display digit
   typedef logic [6:0]  seg_t;         // Segments g..a, active low

   typedef struct packed {
      seg_t digit7;  // Leftmost
      seg_t digit6;
      seg_t digit5;
      seg_t digit4;
      seg_t digit3;
      seg_t digit2;
      seg_t digit1;
      seg_t digit0;  // Rightmost
   } hex_digits_t;

   typedef struct packed {
      logic       write;  // 1 = register write
      reg_index_t index;  // Sent in the command phase
      enet_word_t wdata;  // Write data only
   } bus_req_t;

   typedef struct packed {
      enet_word_t hi;  // Receive status word
      enet_word_t lo;  // Byte length
   } rx_header_t;

   typedef enum logic [2:0] {
      chip_reset,
      read_link,
      idle,
      read_isr,
      read_header_status,
      read_header_len,
      read_data,
      clear_isr
   } feed_state_t;

   localparam int POR_CYCLES       = 16;
   localparam int CHIP_RST_CYCLES  = 8;
   localparam int BUS_PHASE_CYCLES = 4;    // Setup, 2 strobe, hold
   localparam int FIFO_DEPTH       = 128;

   localparam reg_index_t REG_NSR   = 8'h01;  // Network status
   localparam int         NSR_LINK_BIT = 6;
   localparam reg_index_t REG_ISR   = 8'hFE;  // Interrupt status
   localparam int         ISR_PR_BIT = 0;     // Packet received
   localparam reg_index_t REG_MRCMD = 8'hF2;  // Memory read, auto increment
   localparam logic [7:0] RX_READY  = 8'h01;  // Header status low byte, packet valid

   localparam seg_t SEG_BLANK = 7'h7F;

endpackage

`default_nettype wire
